// File: Makefile
SIM      = verilator
TOP      = tb_cache
FILELIST = tb.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
RUNARGS  = +verilator+error+limit+1000
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) $(RUNARGS) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

lint:
	$(SIM) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Address and data widths, 16-bit CPU with byte addressing
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

// Geometry of the 2 KB, 2-way cache
`define CACHE_SETS   64
`define CACHE_WORDS  8
`define CACHE_TAG_W  6

// Field widths inside a byte address
`define CACHE_SET_W  6   // Index bits 9 to 4
`define CACHE_WORD_W 3   // Word offset bits 3 to 1

// Credits handed out at reset
`define CPU_CREDITS  1   // One request outstanding on the CPU side
`define MEM_CREDITS  2   // Two word requests in flight towards memory

`endif

// File: source/cache_arrays.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_arrays (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cache_geom_pkg::set_idx_t   set,        // Set for both read and write
  input  cache_geom_pkg::word_idx_t  word,       // Word within the block
  input  logic                       data_we,    // Data write strobe
  input  logic                       data_way,   // Way that takes the data write
  input  cache_geom_pkg::word_t      data_in,
  input  logic                       tag_we,     // Writes both entries of the set
  input  cache_geom_pkg::tag_entry_t tag_in0,
  input  cache_geom_pkg::tag_entry_t tag_in1,
  output cache_geom_pkg::word_t      data_out0,  // Word from way 0
  output cache_geom_pkg::word_t      data_out1,  // Word from way 1
  output cache_geom_pkg::tag_entry_t tag_out0,
  output cache_geom_pkg::tag_entry_t tag_out1
);

  import cache_geom_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Two ways of 64 blocks with 8 words each, indexed directly by the address fields
  word_t      data_mem [2][`CACHE_SETS][`CACHE_WORDS];
  tag_entry_t meta_mem [`CACHE_SETS][2];  // Tag, valid and LRU per way

  // Data write, one word per cycle into the chosen way
  always_ff @(posedge clk) begin
    if (data_we) begin
      data_mem[data_way][set][word] <= data_in;
    end
  end

  // Metadata write, both ways at once so the LRU bits stay in step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        meta_mem[s][0] <= '0;  // Invalid, LRU points at way 0
        meta_mem[s][1] <= '0;
      end
    end else if (tag_we) begin
      meta_mem[set][0] <= tag_in0;
      meta_mem[set][1] <= tag_in1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Combinational read ports
  //////////////////////////////////////////////////////////////////////

  assign data_out0 = data_mem[0][set][word];
  assign data_out1 = data_mem[1][set][word];
  assign tag_out0  = meta_mem[set][0];  // The lookup compares both entries in parallel
  assign tag_out1  = meta_mem[set][1];

endmodule

// File: source/cache_geom_pkg.sv
`include "cache_defs.svh"

// Types that describe what the cache stores and how an address is cut up
package cache_geom_pkg;

  // Byte address as seen by the CPU
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;

  // One data word, also the unit of every memory transfer
  typedef logic [`CACHE_DATA_W-1:0] word_t;

  // Address fields
  typedef logic [`CACHE_SET_W-1:0]  set_idx_t;   // Bits 9 to 4
  typedef logic [`CACHE_WORD_W-1:0] word_idx_t;  // Bits 3 to 1
  typedef logic [`CACHE_TAG_W-1:0]  tag_t;       // Bits 15 to 10

  // Metadata entry per way, 8 bits with the tag on top
  typedef struct packed {
    tag_t tag;    // Upper address bits of the resident block
    logic valid;  // Block holds real data
    logic lru;    // Way that was not used last, kept equal in both entries of a set
  } tag_entry_t;

endpackage

// File: source/cache_lookup.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_lookup (
  input  cache_geom_pkg::addr_t      addr,        // Address of the latched request
  input  cache_geom_pkg::tag_entry_t tag_out0,    // Metadata of way 0 for this set
  input  cache_geom_pkg::tag_entry_t tag_out1,    // Metadata of way 1 for this set
  output cache_geom_pkg::set_idx_t   set,
  output cache_geom_pkg::word_idx_t  word,
  output cache_geom_pkg::tag_t       tag,
  output logic                       hit,
  output logic                       hit_way,     // Way that matched, only meaningful on a hit
  output logic                       victim_way   // Way a fill would replace
);

  logic match0;  // Way 0 holds this tag
  logic match1;  // Way 1 holds this tag

  // Field slicing, bit 0 is the byte within a word and is ignored
  assign word = addr[1 +: `CACHE_WORD_W];
  assign set  = addr[1 + `CACHE_WORD_W +: `CACHE_SET_W];
  assign tag  = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

  // Both ways compared at once, a match needs the valid bit as well
  assign match0 = tag_out0.valid && (tag_out0.tag == tag);
  assign match1 = tag_out1.valid && (tag_out1.tag == tag);

  assign hit     = match0 | match1;
  assign hit_way = match1;  // Way 0 unless way 1 matched

  // Empty ways are filled first, way 0 before way 1
  always_comb begin
    if (!tag_out0.valid) begin
      victim_way = 1'b0;
    end else if (!tag_out1.valid) begin
      victim_way = 1'b1;
    end else begin
      victim_way = tag_out0.lru;  // Set LRU bit names the way not used last
    end
  end

endmodule

// File: source/cache_miss_ctrl.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_miss_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cache_txn_pkg::cpu_req_t    cpu_req,
  input  logic                       mem_credit,   // Memory freed a request slot
  input  cache_txn_pkg::mem_rsp_t    mem_rsp,
  input  logic                       hit,
  input  logic                       hit_way,
  input  logic                       victim_way,
  input  cache_geom_pkg::set_idx_t   set,
  input  cache_geom_pkg::tag_t       tag,
  input  cache_geom_pkg::tag_entry_t tag_out0,
  input  cache_geom_pkg::tag_entry_t tag_out1,
  output cache_geom_pkg::addr_t      cur_addr,     // Latched request address, feeds the lookup
  output cache_txn_pkg::mem_req_t    mem_req,
  output logic                       data_we,
  output logic                       data_way,
  output cache_geom_pkg::word_idx_t  data_word,
  output cache_geom_pkg::word_t      data_in,
  output logic                       tag_we,
  output cache_geom_pkg::tag_entry_t tag_in0,
  output cache_geom_pkg::tag_entry_t tag_in1,
  output logic                       rsp_fire,     // Response goes out on the next edge
  output logic                       rsp_hit,
  output logic                       rsp_is_read
);

  import cache_geom_pkg::*;
  import cache_txn_pkg::*;

  localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

  ctrl_state_e       state, state_nxt;
  cpu_op_e           cur_op;        // Operation of the latched request
  word_t             cur_wdata;     // Write data of the latched request
  logic [CRED_W-1:0] mem_cred_cnt;  // Memory slots we may still use
  word_idx_t         issue_cnt;     // Next fill word to request
  word_idx_t         ret_cnt;       // Next fill word to come back
  logic              fill_way;      // Victim chosen at lookup, fixed for the whole fill
  logic              hit_q;         // Hit flag of the lookup, reported at the end
  logic              issue;         // A mem_req leaves this cycle
  logic              fill_active;
  logic              lru_way;       // Way that becomes most recently used

  assign fill_active = (state == ST_FILL) || (state == ST_FILL_WAIT);
  assign rsp_is_read = (cur_op == CPU_READ);

  //////////////////////////////////////////////////////////////////////
  // Next state and datapath strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    issue     = 1'b0;
    mem_req   = '0;
    data_we   = 1'b0;
    data_way  = hit_way;           // Write hits go to the matching way
    data_word = cur_addr[1 +: `CACHE_WORD_W];
    data_in   = cur_wdata;
    tag_we    = 1'b0;
    rsp_fire  = 1'b0;
    rsp_hit   = hit_q;
    case (state)
      ST_IDLE: begin
        if (cpu_req.valid) state_nxt = ST_LOOKUP;
      end
      ST_LOOKUP: begin
        if (cur_op == CPU_READ) begin
          if (hit) begin
            tag_we    = 1'b1;      // LRU update only
            rsp_fire  = 1'b1;
            rsp_hit   = 1'b1;
            state_nxt = ST_IDLE;
          end else begin
            state_nxt = ST_FILL;
          end
        end else begin
          data_we   = hit;         // No allocate on a write miss
          tag_we    = hit;
          state_nxt = ST_WRITE_MEM;
        end
      end
      ST_FILL, ST_FILL_WAIT: begin
        data_way  = fill_way;
        data_word = ret_cnt;       // Words return in request order
        data_in   = mem_rsp.rdata;
        data_we   = mem_rsp.valid;
        if (state == ST_FILL && mem_cred_cnt != '0) begin
          issue   = 1'b1;
          mem_req = '{valid: 1'b1, write: 1'b0, addr: {tag, set, issue_cnt, 1'b0}, wdata: '0};
          if (issue_cnt == '1) state_nxt = ST_FILL_WAIT;  // Eighth read is out
        end
        if (state == ST_FILL_WAIT && mem_rsp.valid && ret_cnt == '1) begin
          tag_we    = 1'b1;        // Tag goes in with the last word
          state_nxt = ST_RESPOND;
        end
      end
      ST_WRITE_MEM: begin
        if (mem_cred_cnt != '0) begin
          issue     = 1'b1;
          mem_req   = '{valid: 1'b1, write: 1'b1, addr: cur_addr, wdata: cur_wdata};
          rsp_fire  = 1'b1;        // Writes get no memory response
          state_nxt = ST_IDLE;
        end
      end
      ST_RESPOND: begin
        rsp_fire  = 1'b1;          // Lookup now hits the filled way
        state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Metadata update
  //////////////////////////////////////////////////////////////////////

  assign lru_way = fill_active ? fill_way : hit_way;

  always_comb begin
    tag_in0 = tag_out0;
    tag_in1 = tag_out1;
    if (fill_active) begin
      if (fill_way) begin
        tag_in1.tag   = tag;
        tag_in1.valid = 1'b1;
      end else begin
        tag_in0.tag   = tag;
        tag_in0.valid = 1'b1;
      end
    end
    tag_in0.lru = ~lru_way;  // The other way becomes the replacement candidate
    tag_in1.lru = ~lru_way;
  end

  //////////////////////////////////////////////////////////////////////
  // State, credits and fill counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      mem_cred_cnt <= CRED_W'(`MEM_CREDITS);
      issue_cnt    <= '0;
      ret_cnt      <= '0;
      fill_way     <= 1'b0;
      hit_q        <= 1'b0;
    end else begin
      state        <= state_nxt;
      mem_cred_cnt <= mem_cred_cnt - CRED_W'(issue) + CRED_W'(mem_credit);
      if (state == ST_LOOKUP) begin
        hit_q     <= hit;
        fill_way  <= victim_way;
        issue_cnt <= '0;
        ret_cnt   <= '0;
      end
      if (issue && fill_active) issue_cnt <= issue_cnt + 1'b1;
      if (data_we && fill_active) ret_cnt <= ret_cnt + 1'b1;  // Wraps to 0 after word 7
    end
  end

  // Request payload, taken when the CPU spends its credit
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cpu_req.valid) begin
      cur_addr  <= cpu_req.addr;
      cur_op    <= cpu_req.op;
      cur_wdata <= cpu_req.wdata;
    end
  end

endmodule

// File: source/cache_result.sv
`timescale 1ns/1ps

module cache_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rsp_fire,     // Controller finished the transaction
  input  logic                    rsp_hit,
  input  logic                    rsp_is_read,
  input  logic                    hit_way,
  input  cache_geom_pkg::word_t   data_out0,
  input  cache_geom_pkg::word_t   data_out1,
  output cache_txn_pkg::cpu_rsp_t cpu_rsp,
  output logic                    cpu_credit    // Hands the single CPU credit back
);

  import cache_geom_pkg::*;

  word_t sel_word;  // Word from the hit way, zero for writes

  assign sel_word = rsp_is_read ? (hit_way ? data_out1 : data_out0) : '0;

  // Response and credit leave together for exactly one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_rsp    <= '0;
      cpu_credit <= 1'b0;
    end else begin
      cpu_rsp.valid <= rsp_fire;
      cpu_rsp.hit   <= rsp_fire & rsp_hit;
      cpu_rsp.rdata <= rsp_fire ? sel_word : '0;
      cpu_credit    <= rsp_fire;
    end
  end

endmodule

// File: source/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cache_txn_pkg::cpu_req_t cpu_req,
  input  logic                    mem_credit,
  input  cache_txn_pkg::mem_rsp_t mem_rsp,
  output cache_txn_pkg::cpu_rsp_t cpu_rsp,
  output logic                    cpu_credit,
  output cache_txn_pkg::mem_req_t mem_req
);

  import cache_geom_pkg::*;

  addr_t      cur_addr;
  set_idx_t   lkp_set;
  word_idx_t  lkp_word, data_word, arr_word;
  tag_t       lkp_tag;
  tag_entry_t tag_out0, tag_out1, tag_in0, tag_in1;
  word_t      data_out0, data_out1, data_in;
  logic       hit, hit_way, victim_way;
  logic       data_we, data_way, tag_we;
  logic       rsp_fire, rsp_hit, rsp_is_read;

  // Fill writes use the returning word index, everything else the request word
  assign arr_word = data_we ? data_word : lkp_word;

  cache_arrays u_arrays (
    .clk, .rst_n, .set(lkp_set), .word(arr_word),
    .data_we, .data_way, .data_in, .tag_we, .tag_in0, .tag_in1,
    .data_out0, .data_out1, .tag_out0, .tag_out1
  );

  cache_lookup u_lookup (
    .addr(cur_addr), .tag_out0, .tag_out1,
    .set(lkp_set), .word(lkp_word), .tag(lkp_tag), .hit, .hit_way, .victim_way
  );

  cache_miss_ctrl u_ctrl (
    .clk, .rst_n, .cpu_req, .mem_credit, .mem_rsp, .hit, .hit_way, .victim_way,
    .set(lkp_set), .tag(lkp_tag), .tag_out0, .tag_out1, .cur_addr, .mem_req,
    .data_we, .data_way, .data_word, .data_in, .tag_we, .tag_in0, .tag_in1,
    .rsp_fire, .rsp_hit, .rsp_is_read
  );

  cache_result u_result (
    .clk, .rst_n, .rsp_fire, .rsp_hit, .rsp_is_read, .hit_way,
    .data_out0, .data_out1, .cpu_rsp, .cpu_credit
  );

endmodule

// File: source/cache_txn_pkg.sv
`include "cache_defs.svh"

// Transactions on the CPU and memory channels, plus the controller states
package cache_txn_pkg;

  import cache_geom_pkg::*;

  // CPU operation
  typedef enum logic {
    CPU_READ  = 1'b0,
    CPU_WRITE = 1'b1
  } cpu_op_e;

  // Request from the CPU, one credit per request
  typedef struct packed {
    logic    valid;
    cpu_op_e op;
    addr_t   addr;
    word_t   wdata;
  } cpu_req_t;

  // Response to the CPU, rdata is zero for writes
  typedef struct packed {
    logic  valid;
    logic  hit;
    word_t rdata;
  } cpu_rsp_t;

  // Word request towards memory
  typedef struct packed {
    logic  valid;
    logic  write;  // High for write-through, low for a fill read
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // Read data from memory, returned in request order
  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_FILL,
    ST_FILL_WAIT,
    ST_WRITE_MEM,
    ST_RESPOND
  } ctrl_state_e;

endpackage

// File: tb.f
+incdir+include
source/cache_geom_pkg.sv
source/cache_txn_pkg.sv
source/cache_arrays.sv
source/cache_lookup.sv
source/cache_miss_ctrl.sv
source/cache_result.sv
source/cache_top.sv
tb/cache_assert.sv
tb/cache_checker.sv
tb/tb_cache.sv

// File: tb/cache_assert.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_assert (
  input logic                                   clk,
  input logic                                   rst_n,
  input cache_txn_pkg::cpu_req_t                cpu_req,
  input cache_txn_pkg::ctrl_state_e             state,         // Controller state
  input cache_txn_pkg::mem_req_t                mem_req,
  input logic                                   mem_credit,    // Memory freed a request slot
  input logic [$clog2(`MEM_CREDITS + 1)-1:0]    mem_cred_cnt   // Controller's memory credits
);

  import cache_txn_pkg::*;

  int fail_cnt = 0;  // Read by the testbench top for the closing verdict
  int in_flight;     // Memory requests sent whose credit has not come back yet

  // Slots in use at the memory, counted from the channel itself
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(mem_req.valid) - int'(mem_credit);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit rules on the memory channel
  //////////////////////////////////////////////////////////////////////

  a_req_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.valid |-> in_flight < `MEM_CREDITS)
    else begin
      $error("Memory request issued with every slot in use");
      fail_cnt++;
    end

  a_credit_ceiling: assert property (@(posedge clk) disable iff (!rst_n)
    mem_cred_cnt <= `MEM_CREDITS)
    else begin
      $error("Memory credit count above its reset value");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // Handshake on the CPU channel
  //////////////////////////////////////////////////////////////////////

  // The CPU sends only with its credit in hand, so a request never meets a busy controller
  a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_req.valid |-> state == ST_IDLE)
    else begin
      $error("CPU request arrived while the controller was busy");
      fail_cnt++;
    end

endmodule

bind cache_miss_ctrl cache_assert u_assert (
  .clk, .rst_n, .cpu_req, .state, .mem_req, .mem_credit, .mem_cred_cnt
);

// File: tb/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cache_txn_pkg::cpu_rsp_t cpu_rsp,
  input  logic                    cpu_credit,
  input  logic                    exp_load,   // A request left with this expectation
  input  logic [127:0]            exp_name,   // Test name as characters
  input  cache_geom_pkg::word_t   exp_rdata,
  input  logic                    exp_hit,
  output int                      n_pass,
  output int                      n_fail
);

  import cache_geom_pkg::*;

  logic         pending;  // Waiting for the response of the latched test
  logic [127:0] name_q;
  word_t        rdata_q;
  logic         hit_q;

  initial begin
    pending = 1'b0;
    n_pass  = 0;
    n_fail  = 0;
  end

  // Sampled mid cycle, where the registered response is stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (cpu_rsp.valid != cpu_credit) begin
        $display("Response valid and CPU credit out of step during %0s", name_q);
        n_fail++;
      end
      if (cpu_rsp.valid) begin
        if (!pending) begin
          $display("Response arrived with no request outstanding");
          n_fail++;
        end else if (cpu_rsp.hit !== hit_q || cpu_rsp.rdata !== rdata_q) begin
          $display("Mismatch %0s: expected hit %0d data %h, actual hit %0d data %h",
                   name_q, hit_q, rdata_q, cpu_rsp.hit, cpu_rsp.rdata);
          n_fail++;
        end else begin
          $display("Pass %0s: hit %0d data %h", name_q, cpu_rsp.hit, cpu_rsp.rdata);
          n_pass++;
        end
        pending = 1'b0;
      end
      if (exp_load) begin
        if (pending) begin
          $display("No response for test %0s before the next request", name_q);
          n_fail++;
        end
        name_q  = exp_name;  // Latch the next test's expectation
        rdata_q = exp_rdata;
        hit_q   = exp_hit;
        pending = 1'b1;
      end
    end
  end

endmodule

// File: tb/cache_input.txt
# name op(R/W) addr wdata exp_rdata exp_hit, all hex except exp_hit
# set 3 takes tags 01 02 03 in turn, tag 07 in set 5 is the write miss
cold_miss    R 0432 0000 a1f1 0
hit_word7    R 043e 0000 a1fd 1
hit_word0    R 0430 0000 a1f3 1
tag2_miss    R 0836 0000 adf5 0
tag1_hit     R 0434 0000 a1f7 1
tag3_evict   R 0c38 0000 a9fb 0
tag1_kept    R 043c 0000 a1ff 1
tag2_gone    R 0830 0000 adf3 0
wr_hit       W 043a 1234 0000 1
rd_after_wr  R 043a 0000 1234 1
wr_miss      W 1c50 beef 0000 0
rd_wr_miss   R 1c50 0000 beef 0

// File: tb/tb_cache.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache;

  import cache_geom_pkg::*;
  import cache_txn_pkg::*;

  localparam int MAX_TESTS = 64;
  localparam int MEM_WORDS = 1 << (`CACHE_ADDR_W - 1);  // Word organized backing store
  localparam int DRIVE_DLY = 1;                          // Inputs change this long after posedge

  logic     clk;
  logic     rst_n;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  logic     cpu_credit;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     mem_credit;

  logic         exp_load;   // Expectation handed to the checker with each request
  logic [127:0] exp_name;
  word_t        exp_rdata;
  logic         exp_hit;
  int           n_pass;
  int           n_fail;

  // Tests as read from the data file
  logic [127:0] t_name  [MAX_TESTS];
  logic         t_write [MAX_TESTS];
  addr_t        t_addr  [MAX_TESTS];
  word_t        t_wdata [MAX_TESTS];
  word_t        t_rdata [MAX_TESTS];
  logic         t_hit   [MAX_TESTS];
  int           n_tests;
  int           credits;  // CPU credits held by the testbench
  int           limit;    // Timeout in cycles after reset, zero until the tests are known
  int           run_cyc;

  // Memory model, two slots, answers in request order
  word_t mem [MEM_WORDS];
  int    q_ready [$];     // Cycle at which the head may leave
  logic  q_write [$];
  word_t q_data  [$];
  int    mcyc;
  int    last_ready;
  int    seed;

  cache_top dut0 (
    .clk, .rst_n, .cpu_req, .mem_credit, .mem_rsp, .cpu_rsp, .cpu_credit, .mem_req
  );

  cache_checker chk0 (
    .clk, .rst_n, .cpu_rsp, .cpu_credit, .exp_load, .exp_name, .exp_rdata, .exp_hit,
    .n_pass, .n_fail
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  // Requests are sampled mid cycle and count as taken at the next edge
  always @(negedge clk) begin : mem_accept
    int lat;
    int ready;
    if (rst_n && mem_req.valid) begin
      lat   = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
      ready = mcyc + lat;
      if (ready <= last_ready) ready = last_ready + 1;  // Keeps answers in order
      last_ready = ready;
      q_ready.push_back(ready);
      q_write.push_back(mem_req.write);
      if (mem_req.write) begin
        mem[mem_req.addr[15:1]] = mem_req.wdata;
        q_data.push_back('0);
      end else begin
        q_data.push_back(mem[mem_req.addr[15:1]]);
      end
    end
  end

  always @(posedge clk) begin
    mcyc++;
    #DRIVE_DLY;
    mem_rsp    = '0;
    mem_credit = 1'b0;
    if (q_ready.size() > 0 && q_ready[0] <= mcyc) begin
      mem_credit    = 1'b1;        // The slot is free again
      mem_rsp.valid = !q_write[0]; // Writes only give the credit back
      mem_rsp.rdata = q_write[0] ? '0 : q_data[0];
      void'(q_ready.pop_front());
      void'(q_write.pop_front());
      void'(q_data.pop_front());
    end
  end

  // Cycle limit, counted once reset is released
  always @(posedge clk) begin
    if (rst_n && limit > 0) begin
      run_cyc++;
      if (run_cyc >= limit) begin
        $display("Timeout after %0d cycles, a response never arrived", run_cyc);
        $display("Test FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int              fd;
    int              cnt;
    int              hit;
    logic [8*80-1:0] line;
    logic [127:0]    name;
    logic [7:0]      op;
    logic [15:0]     addr, wdata, rdata;
    n_tests = 0;
    fd = $fopen("tb/cache_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/cache_input.txt, no tests to run");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%s %s %h %h %h %d", name, op, addr, wdata, rdata, hit);
          if (cnt == 6) begin  // Comment and blank lines give fewer fields
            t_name[n_tests]  = name;
            t_write[n_tests] = (op == "W");
            t_addr[n_tests]  = addr;
            t_wdata[n_tests] = wdata;
            t_rdata[n_tests] = rdata;
            t_hit[n_tests]   = hit[0];
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One request, then wait until its credit comes back
  task automatic run_test(input int i);
    @(posedge clk);
    #DRIVE_DLY;
    cpu_req.valid = 1'b1;
    cpu_req.op    = t_write[i] ? CPU_WRITE : CPU_READ;
    cpu_req.addr  = t_addr[i];
    cpu_req.wdata = t_wdata[i];
    exp_load      = 1'b1;
    exp_name      = t_name[i];
    exp_rdata     = t_rdata[i];
    exp_hit       = t_hit[i];
    credits--;
    @(posedge clk);
    #DRIVE_DLY;
    cpu_req  = '0;
    exp_load = 1'b0;
    while (credits == 0) begin
      @(negedge clk);
      if (cpu_credit) credits++;
    end
  endtask

  task automatic report();
    int assert_fails;
    assert_fails = dut0.u_ctrl.u_assert.fail_cnt;
    $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
             n_tests, n_pass, n_fail, assert_fails);
    if (n_tests > 0 && n_fail == 0 && n_pass == n_tests && assert_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cpu_req    = '0;
    mem_rsp    = '0;
    mem_credit = 1'b0;
    exp_load   = 1'b0;
    exp_name   = '0;
    exp_rdata  = '0;
    exp_hit    = 1'b0;
    credits    = `CPU_CREDITS;
    run_cyc    = 0;
    limit      = 0;
    mcyc       = 0;
    last_ready = 0;
    seed       = 32'h5d92_7123;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 16'(i << 1) ^ 16'hA5C3;  // Byte address of the word, scrambled
    end
    load_tests();
    limit = n_tests * `CACHE_WORDS * 4 + 20;  // A full fill per test at worst latency
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    repeat (3) @(posedge clk);  // Let the checker see the last response
    report();
  end

endmodule
